//--- rtl/branch_pkg.sv
// Core types of the branch unit with widths, flag positions and condition opcodes.
`default_nettype none

package branch_pkg;

    // ========================================
    // datapath widths
    // ========================================

    localparam int pc_width    = 10;                 // program counter and destination width.
    localparam int flags_width = 4;                  // one bit per ALU flag.

    // bit positions inside the flags word.
    localparam int flag_zero     = 0;
    localparam int flag_negative = 1;
    localparam int flag_carry    = 2;
    localparam int flag_overflow = 3;

    // ========================================
    // branch conditions
    // ========================================

    // The condition table keeps one of these in bits 2:0 of its word.
    typedef enum logic [2:0] {
        cond_never        = 3'd0,                    // never taken, also the value after reset.
        cond_always       = 3'd1,
        cond_zero         = 3'd2,
        cond_not_zero     = 3'd3,
        cond_negative     = 3'd4,
        cond_not_negative = 3'd5,
        cond_carry        = 3'd6,
        cond_overflow     = 3'd7
    } cond_op_t;

    localparam int cond_width = $bits(cond_op_t);    // stored field width of a condition.

endpackage

`default_nettype wire

//--- rtl/branch_map_pkg.sv
// APB memory map of the branch tables and the decoded table select.
`default_nettype none

package branch_map_pkg;

    localparam int apb_addr_width = 12;
    localparam int apb_data_width = 32;

    // ========================================
    // table windows
    // ========================================

    localparam logic [apb_addr_width-1:0] origin_base      = 12'h000;
    localparam logic [apb_addr_width-1:0] destination_base = 12'h040;
    localparam logic [apb_addr_width-1:0] condition_base   = 12'h080;

    localparam int window_shift = 6;                 // each window spans 64 bytes.
    localparam int word_shift   = 2;                 // one 32-bit word per thread.
    localparam int slot_width   = window_shift - word_shift;

    // Which table an access goes to.
    typedef enum logic [1:0] {
        sel_origin      = 2'd0,
        sel_destination = 2'd1,
        sel_condition   = 2'd2,
        sel_none        = 2'd3                       // address outside all three windows.
    } table_sel_t;

endpackage

`default_nettype wire

//--- rtl/branch_cfg_if.sv
// Decoded table access path from the APB slave to the branch tables.
`timescale 1ns/1ps
`default_nettype none

interface branch_cfg_if #(
    parameter int thread_count = 8
);
    import branch_map_pkg::*;

    localparam int thread_width = $clog2(thread_count);

    logic                      wr_en;                // one cycle per APB write access.
    logic                      rd_en;                // high during a mapped read access.
    table_sel_t                sel;
    logic [thread_width-1:0]   thread;
    logic [apb_data_width-1:0] wdata;
    logic [apb_data_width-1:0] rdata;                // combinational from the tables.

    modport decoder (
        output wr_en, rd_en, sel, thread, wdata,
        input  rdata
    );

    modport tables (
        input  wr_en, rd_en, sel, thread, wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- rtl/branch_map_decoder.sv
// APB slave that turns bus accesses into per-table writes and read selects.
`timescale 1ns/1ps
`default_nettype none

module branch_map_decoder #(
    parameter int thread_count = 8
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     psel,
    input  logic                                     penable,
    input  logic                                     pwrite,
    input  logic [branch_map_pkg::apb_addr_width-1:0] paddr,
    input  logic [branch_map_pkg::apb_data_width-1:0] pwdata,
    output logic [branch_map_pkg::apb_data_width-1:0] prdata,
    output logic                                     pready,
    output logic                                     pslverr,
    branch_cfg_if.decoder                            cfg
);
    import branch_map_pkg::*;

    localparam int thread_width = $clog2(thread_count);
    localparam int window_width = apb_addr_width - window_shift;

    logic                    access;
    logic [window_width-1:0] window;
    logic [slot_width-1:0]   slot;
    table_sel_t              sel;
    logic                    slot_ok;
    logic                    mapped;

    // ========================================
    // address decode
    // ========================================

    assign access = psel && penable;                 // APB access phase.
    assign window = paddr[apb_addr_width-1:window_shift];
    assign slot   = paddr[window_shift-1:word_shift];

    always_comb begin
        if (window == origin_base[apb_addr_width-1:window_shift]) begin
            sel = sel_origin;
        end else if (window == destination_base[apb_addr_width-1:window_shift]) begin
            sel = sel_destination;
        end else if (window == condition_base[apb_addr_width-1:window_shift]) begin
            sel = sel_condition;
        end else begin
            sel = sel_none;
        end
    end

    // Slots past the last thread sit inside a window but hold no table word.
    assign slot_ok = int'(slot) < thread_count;
    assign mapped  = (sel != sel_none) && slot_ok;

    // ========================================
    // table access and APB response
    // ========================================

    assign cfg.wr_en  = access && pwrite && mapped;  // single pulse, no wait states.
    assign cfg.rd_en  = access && !pwrite && mapped;
    assign cfg.sel    = sel;
    assign cfg.thread = slot[thread_width-1:0];
    assign cfg.wdata  = pwdata;

    assign prdata  = cfg.rdata;                      // tables drive zero when rd_en is low.
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    // The access phase must always sit inside a selected transfer.
    penable_needs_psel: assert property (
        @(posedge clock) disable iff (reset)
        penable |-> psel
    ) else $error("penable high without psel");

endmodule

`default_nettype wire

//--- rtl/branch_check.sv
// Per-thread branch tables with origin compare and condition evaluation.
`timescale 1ns/1ps
`default_nettype none

module branch_check #(
    parameter int thread_count   = 8,
    parameter int initial_thread = 0
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [branch_pkg::pc_width-1:0]    pc,
    input  logic [branch_pkg::flags_width-1:0] flags,
    input  logic                               io_ready_previous,
    branch_cfg_if.tables                       cfg,
    output logic                               hit,
    output logic [branch_pkg::pc_width-1:0]    target,
    output logic                               io_ready_out,
    output logic [$clog2(thread_count)-1:0]    thread
);
    import branch_pkg::*;
    import branch_map_pkg::*;

    localparam int thread_width = $clog2(thread_count);
    localparam logic [thread_width-1:0] last_thread = thread_width'(thread_count - 1);
    localparam logic [thread_width-1:0] first_thread = thread_width'(initial_thread);

    logic [thread_width-1:0] thread_cnt;             // thread that owns the current pc.
    logic [pc_width-1:0]     origin      [thread_count];
    logic [pc_width-1:0]     destination [thread_count];
    cond_op_t                condition   [thread_count];
    logic                    origin_match;
    logic                    cond_true;

    // Evaluates one condition opcode against the ALU flags.
    function automatic logic cond_holds(cond_op_t op, logic [flags_width-1:0] f);
        logic result;
        result = 1'b0;
        case (op)
            cond_never:        result = 1'b0;
            cond_always:       result = 1'b1;
            cond_zero:         result = f[flag_zero];
            cond_not_zero:     result = !f[flag_zero];
            cond_negative:     result = f[flag_negative];
            cond_not_negative: result = !f[flag_negative];
            cond_carry:        result = f[flag_carry];
            cond_overflow:     result = f[flag_overflow];
            default:           result = 1'b0;
        endcase
        return result;
    endfunction

    // ========================================
    // thread sequencer
    // ========================================

    always_ff @(posedge clock) begin
        if (reset) begin
            thread_cnt <= first_thread;
        end else if (thread_cnt == last_thread) begin
            thread_cnt <= '0;                        // wrap back to thread zero.
        end else begin
            thread_cnt <= thread_cnt + 1'b1;
        end
    end

    // ========================================
    // branch tables
    // ========================================

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < thread_count; i++) begin
                origin[i]      <= '0;
                destination[i] <= '0;
                condition[i]   <= cond_never;
            end
        end else if (cfg.wr_en) begin
            // Each table keeps only the low field bits of the bus word.
            case (cfg.sel)
                sel_origin:      origin[cfg.thread]      <= cfg.wdata[pc_width-1:0];
                sel_destination: destination[cfg.thread] <= cfg.wdata[pc_width-1:0];
                sel_condition:   condition[cfg.thread]   <=
                                     cond_op_t'(cfg.wdata[cond_width-1:0]);
                default: ;
            endcase
        end
    end

    always_comb begin
        cfg.rdata = '0;
        if (cfg.rd_en) begin
            case (cfg.sel)
                sel_origin:      cfg.rdata[pc_width-1:0]   = origin[cfg.thread];
                sel_destination: cfg.rdata[pc_width-1:0]   = destination[cfg.thread];
                sel_condition:   cfg.rdata[cond_width-1:0] = condition[cfg.thread];
                default: ;
            endcase
        end
    end

    // ========================================
    // branch decision
    // ========================================

    assign origin_match = (pc == origin[thread_cnt]);
    assign cond_true    = cond_holds(condition[thread_cnt], flags);

    always_ff @(posedge clock) begin
        if (reset) begin
            hit          <= 1'b0;
            io_ready_out <= 1'b0;
            thread       <= first_thread;
        end else begin
            hit          <= origin_match && cond_true;
            io_ready_out <= io_ready_previous;       // annul travels with its pc.
            thread       <= thread_cnt;
        end
    end

    always_ff @(posedge clock) begin
        target <= destination[thread_cnt];
    end

    thread_in_range: assert property (
        @(posedge clock) disable iff (reset)
        int'(thread_cnt) < thread_count
    ) else $error("thread index %0d out of range", thread_cnt);

endmodule

`default_nettype wire

//--- rtl/branch_output_stage.sv
// Final branch stage with I/O annul and the per-thread back-to-back jump block.
`timescale 1ns/1ps
`default_nettype none

module branch_output_stage #(
    parameter int thread_count   = 8,
    parameter int initial_thread = 0
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            hit,
    input  logic [branch_pkg::pc_width-1:0] target,
    input  logic                            io_ready,
    input  logic [$clog2(thread_count)-1:0] thread,
    output logic                            jump,
    output logic [branch_pkg::pc_width-1:0] branch_destination
);
    localparam int thread_width = $clog2(thread_count);

    logic [thread_count-1:0] prev_jump;              // did this thread jump on its last turn.
    logic                    take;

    // A stalled instruction or a jump right after a jump is dropped.
    assign take = hit && io_ready && !prev_jump[thread];

    always_ff @(posedge clock) begin
        if (reset) begin
            prev_jump <= '0;
            jump      <= 1'b0;
        end else begin
            prev_jump[thread] <= take;               // every turn overwrites its own bit.
            jump              <= take;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            branch_destination <= target;            // holds between jumps.
        end
    end

    // ========================================
    // checks
    // ========================================

    // A thread comes back every thread_count cycles, so that is where its next jump would be.
    no_back_to_back_jump: assert property (
        @(posedge clock) disable iff (reset)
        $past(jump, thread_count) |-> !jump
    ) else $error("thread jumped on two turns in a row");

    // The first decision out of reset belongs to the start thread of the sequencer.
    first_turn_thread: assert property (
        @(posedge clock) disable iff (reset)
        $fell(reset) |=> thread == thread_width'(initial_thread)
    ) else $error("first thread after reset is %0d", thread);

endmodule

`default_nettype wire

//--- rtl/branch_unit_top.sv
// Top level of the branch unit joining the APB slave, the tables and the output stage.
`timescale 1ns/1ps
`default_nettype none

module branch_unit_top #(
    parameter int thread_count   = 8,
    parameter int initial_thread = 0
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [branch_map_pkg::apb_addr_width-1:0] paddr,
    input  logic [branch_map_pkg::apb_data_width-1:0] pwdata,
    output logic [branch_map_pkg::apb_data_width-1:0] prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    input  logic [branch_pkg::pc_width-1:0]           pc,
    input  logic [branch_pkg::flags_width-1:0]        flags,
    input  logic                                      io_ready_previous,
    output logic [branch_pkg::pc_width-1:0]           branch_destination,
    output logic                                      jump
);
    import branch_pkg::*;

    localparam int thread_width = $clog2(thread_count);

    logic                    hit;
    logic [pc_width-1:0]     target;
    logic                    io_ready;
    logic [thread_width-1:0] thread;

    branch_cfg_if #(.thread_count(thread_count)) cfg_if ();

    branch_map_decoder #(
        .thread_count (thread_count)
    ) branch_map_decoder_i (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg_if.decoder)
    );

    branch_check #(
        .thread_count   (thread_count),
        .initial_thread (initial_thread)
    ) branch_check_i (
        .clock             (clock),
        .reset             (reset),
        .pc                (pc),
        .flags             (flags),
        .io_ready_previous (io_ready_previous),
        .cfg               (cfg_if.tables),
        .hit               (hit),
        .target            (target),
        .io_ready_out      (io_ready),
        .thread            (thread)
    );

    branch_output_stage #(
        .thread_count   (thread_count),
        .initial_thread (initial_thread)
    ) branch_output_stage_i (
        .clock              (clock),
        .reset              (reset),
        .hit                (hit),
        .target             (target),
        .io_ready           (io_ready),
        .thread             (thread),
        .jump               (jump),
        .branch_destination (branch_destination)
    );

endmodule

`default_nettype wire

//--- test/branch_tb.sv
// Directed testbench for the branch unit with a table model and APB access tasks.
`timescale 1ns/1ps
`default_nettype none

module branch_tb;
    import branch_pkg::*;
    import branch_map_pkg::*;

    localparam int thread_count   = 8;
    localparam int timeout_cycles = 5000;            // the six tests take under 3000 cycles.

    logic                      clock = 1'b0;
    logic                      reset;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic [pc_width-1:0]       pc;
    logic [flags_width-1:0]    flags;
    logic                      io_ready_previous;
    logic [pc_width-1:0]       branch_destination;
    logic                      jump;

    // model of the tables, the thread sequence and the output stage.
    logic [pc_width-1:0] origin_m [thread_count];
    logic [pc_width-1:0] dest_m   [thread_count];
    logic [2:0]          cond_m   [thread_count];
    bit                  prev_m   [thread_count];
    logic [pc_width-1:0] last_dest = '0;
    bit                  dest_shown = 1'b0;          // the destination output has carried a jump.
    int                  cur_thread;                 // thread of the pc driven at the last edge.
    bit                  exp_jump_q [$];
    logic [pc_width-1:0] exp_dest_q [$];
    bit                  pend_valid = 1'b0;          // write that commits at the next edge.
    logic [11:0]         pend_addr;
    logic [31:0]         pend_data;
    bit                  sched_valid = 1'b0;         // pc held back for one thread's turn.
    int                  sched_thread;
    logic [pc_width-1:0] sched_pc;
    logic [31:0]         rng = 32'h6f73;
    int                  cycles = 0;
    int                  errors = 0;
    int                  test_errors;
    string               test_name;

    branch_unit_top #(
        .thread_count   (thread_count),
        .initial_thread (0)
    ) branch_unit_top_i (
        .clock              (clock),
        .reset              (reset),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .paddr              (paddr),
        .pwdata             (pwdata),
        .prdata             (prdata),
        .pready             (pready),
        .pslverr            (pslverr),
        .pc                 (pc),
        .flags              (flags),
        .io_ready_previous  (io_ready_previous),
        .branch_destination (branch_destination),
        .jump               (jump)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("run stopped after %0d cycles before the tests were done", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ========================================
    // model helpers
    // ========================================

    function automatic logic [31:0] rand_next();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic bit cond_taken(input logic [2:0] op, input logic [3:0] f);
        bit result;
        case (op)
            cond_always:       result = 1'b1;
            cond_zero:         result = f[flag_zero];
            cond_not_zero:     result = ~f[flag_zero];
            cond_negative:     result = f[flag_negative];
            cond_not_negative: result = ~f[flag_negative];
            cond_carry:        result = f[flag_carry];
            cond_overflow:     result = f[flag_overflow];
            default:           result = 1'b0;    // cond_never.
        endcase
        return result;
    endfunction

    // three 64-byte windows with eight words each.
    function automatic bit addr_mapped(input logic [11:0] a);
        return (a[11:6] < 6'd3) && (a[5:2] < 4'd8);
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] a);
        int t;
        t = int'(a[4:2]);
        if (!addr_mapped(a)) return 32'd0;
        case (a[7:6])
            2'd0:    return {22'd0, origin_m[t]};
            2'd1:    return {22'd0, dest_m[t]};
            default: return {29'd0, cond_m[t]};
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL %s: %s expected %0h actual %0h", test_name, what, exp, act);
        errors++;
    endtask

    // ========================================
    // cycle driver and bus tasks
    // ========================================

    // One clock edge. Checks the jump of the pc from three edges back and drives a new pc.
    task automatic tick(input bit idle, input logic [9:0] p, input logic [3:0] f, input bit io);
        bit                  take;
        bit                  exp_j;
        bit                  use_idle;
        logic [pc_width-1:0] exp_d;
        logic [pc_width-1:0] drv_pc;
        logic [3:0]          drv_flags;
        bit                  drv_io;
        @(posedge clock);
        use_idle  = idle;
        drv_pc    = p;
        drv_flags = f;
        drv_io    = io;
        if (exp_jump_q.size() == 3) begin
            exp_j = exp_jump_q.pop_front();
            exp_d = exp_dest_q.pop_front();
            if (exp_j) dest_shown = 1'b1;
            if (jump !== exp_j) report_mismatch("jump", 32'(exp_j), 32'(jump));
            if (dest_shown && branch_destination !== exp_d) begin
                report_mismatch("destination", 32'(exp_d), 32'(branch_destination));
            end
        end
        if (pend_valid && addr_mapped(pend_addr)) begin
            case (pend_addr[7:6])
                2'd0:    origin_m[pend_addr[4:2]] = pend_data[9:0];
                2'd1:    dest_m[pend_addr[4:2]] = pend_data[9:0];
                default: cond_m[pend_addr[4:2]] = pend_data[2:0];
            endcase
        end
        pend_valid = 1'b0;
        cur_thread = (cur_thread + 1) % thread_count;
        if (use_idle && sched_valid && cur_thread == sched_thread) begin
            use_idle    = 1'b0;
            drv_pc      = sched_pc;
            sched_valid = 1'b0;
        end
        if (use_idle) begin
            drv_pc    = origin_m[cur_thread] ^ 10'd1; // idle pcs never match.
            drv_flags = '0;
            drv_io    = 1'b1;
        end
        take = (drv_pc == origin_m[cur_thread]) && cond_taken(cond_m[cur_thread], drv_flags)
               && drv_io && !prev_m[cur_thread];
        prev_m[cur_thread] = take;
        if (take) last_dest = dest_m[cur_thread];
        exp_jump_q.push_back(take);
        exp_dest_q.push_back(last_dest);
        pc                <= drv_pc;
        flags             <= drv_flags;
        io_ready_previous <= drv_io;
    endtask

    task automatic apb_transfer(input bit write, input logic [11:0] a, input logic [31:0] d);
        tick(1'b1, '0, '0, 1'b1);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= a;
        pwdata  <= d;
        tick(1'b1, '0, '0, 1'b1);
        penable <= 1'b1;
        pend_valid = write;
        pend_addr  = a;
        pend_data  = d;
        tick(1'b1, '0, '0, 1'b1);                // access phase ends at this edge.
        if (pready !== 1'b1) report_mismatch("pready", 32'd1, 32'(pready));
        if (pslverr !== !addr_mapped(a)) begin
            report_mismatch("pslverr", 32'(!addr_mapped(a)), 32'(pslverr));
        end
        if ((!write || !addr_mapped(a)) && prdata !== model_read(a)) begin
            report_mismatch("prdata", model_read(a), prdata);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] a, input logic [31:0] d);
        apb_transfer(1'b1, a, d);
    endtask

    task automatic apb_read(input logic [11:0] a);
        apb_transfer(1'b0, a, 32'd0);
    endtask

    // waits for thread t's next turn and presents one pc on it.
    task automatic present(input int t, input logic [9:0] p, input logic [3:0] f, input bit io);
        while ((cur_thread + 1) % thread_count != t) tick(1'b1, '0, '0, 1'b1);
        tick(1'b0, p, f, io);
    endtask

    task automatic readback_all();
        for (int w = 0; w < 3; w++) begin
            for (int t = 0; t < thread_count; t++) apb_read(12'(w * 64 + t * 4));
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        repeat (3) tick(1'b1, '0, '0, 1'b1);    // drain the jump pipeline.
        $display("test %s done with %0d errors", test_name, errors - test_errors);
    endtask

    // ========================================
    // directed tests
    // ========================================

    task automatic test_readback();
        logic [31:0] d;
        start_test("readback");
        for (int w = 0; w < 3; w++) begin
            for (int t = 0; t < thread_count; t++) begin
                d      = rand_next();
                d[9:0] = 10'(w * 128 + t * 9 + 1);   // low field bits differ in every word.
                apb_write(12'(w * 64 + t * 4), d);
            end
        end
        readback_all();
        finish_test();
    endtask

    task automatic test_unmapped();
        start_test("unmapped");
        apb_write(12'h0C0, 32'h3ff);
        apb_write(12'hFFC, 32'h155);
        apb_write(12'h020, 32'h2aa);                 // origin window, thread 8.
        apb_write(12'h07C, 32'h0f0);                 // destination window, thread 15.
        apb_write(12'h0A0, 32'h007);
        apb_read(12'h0C0);
        apb_read(12'h0BC);
        readback_all();
        finish_test();
    endtask

    task automatic test_conditions();
        logic [9:0] p;
        start_test("conditions");
        for (int t = 0; t < thread_count; t++) begin
            p = 10'(rand_next());
            apb_write(origin_base + 12'(t * 4), 32'(p));
            apb_write(destination_base + 12'(t * 4), rand_next());
            for (int op = 0; op < 8; op++) begin
                apb_write(condition_base + 12'(t * 4), 32'(op));
                repeat (2) begin
                    present(t, p, 4'(rand_next()), 1'b1);
                    present(t, p ^ 10'd1, '0, 1'b1); // a miss clears the back-to-back block.
                end
            end
        end
        finish_test();
    endtask

    task automatic test_mismatch_annul();
        start_test("mismatch and annul");
        for (int t = 0; t < thread_count; t++) begin
            apb_write(condition_base + 12'(t * 4), 32'(cond_always));
            present(t, origin_m[t] ^ 10'h200, 4'(rand_next()), 1'b1);
            present(t, origin_m[t] ^ 10'h001, 4'(rand_next()), 1'b1);
            present(t, origin_m[t], 4'(rand_next()), 1'b0);
            present(t, origin_m[t], 4'(rand_next()), 1'b1);
        end
        finish_test();
    endtask

    task automatic test_back_to_back();
        start_test("back to back");
        apb_write(condition_base + 12'd20, 32'(cond_always));
        apb_write(condition_base + 12'd24, 32'(cond_always));
        present(5, origin_m[5] ^ 10'd1, '0, 1'b1);
        present(6, origin_m[6] ^ 10'd1, '0, 1'b1);
        repeat (3) begin
            present(5, origin_m[5], '0, 1'b1);       // jumps, blocked, jumps again.
            present(6, origin_m[6], '0, 1'b1);
        end
        finish_test();
    endtask

    task automatic test_write_then_use();
        logic [9:0] nd;
        start_test("write then use");
        apb_write(condition_base + 12'd8, 32'(cond_always));
        present(2, origin_m[2] ^ 10'd1, '0, 1'b1);
        while (cur_thread != 7) tick(1'b1, '0, '0, 1'b1);
        nd           = dest_m[2] ^ 10'h2aa;
        sched_pc     = origin_m[2];
        sched_thread = 2;
        sched_valid  = 1'b1;
        apb_write(destination_base + 12'd8, 32'(nd)); // commits on the edge of thread 2's pc.
        repeat (3) tick(1'b1, '0, '0, 1'b1);
        if (branch_destination !== nd) begin
            report_mismatch("new destination", 32'(nd), 32'(branch_destination));
        end
        finish_test();
    endtask

    initial begin
        reset             = 1'b1;
        psel              = 1'b0;
        penable           = 1'b0;
        pwrite            = 1'b0;
        paddr             = '0;
        pwdata            = '0;
        pc                = '0;
        flags             = '0;
        io_ready_previous = 1'b1;
        for (int t = 0; t < thread_count; t++) begin
            origin_m[t] = '0;
            dest_m[t]   = '0;
            cond_m[t]   = '0;
            prev_m[t]   = 1'b0;
        end
        cur_thread = thread_count - 1;
        repeat (7) @(posedge clock);
        tick(1'b1, '0, '0, 1'b1);                // the eighth reset edge presents thread 0.
        reset <= 1'b0;
        test_readback();
        test_unmapped();
        test_conditions();
        test_mismatch_annul();
        test_back_to_back();
        test_write_then_use();
        $display("6 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
rtl/branch_pkg.sv
rtl/branch_map_pkg.sv
rtl/branch_cfg_if.sv
rtl/branch_map_decoder.sv
rtl/branch_check.sv
rtl/branch_output_stage.sv
rtl/branch_unit_top.sv
test/branch_tb.sv

//--- run.sh
#!/bin/sh
# Builds the branch unit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --assert -f src.f --top-module branch_tb -Mdir "$build_dir" -o branch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/branch_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$log"; then
    echo "simulation reported a failure, see $log"
    exit 1
fi

echo "simulation finished without failure"
exit 0
